/* hdl/fpd_pkg.sv */
`default_nettype none

package fpd_pkg;

    // opcodes
    localparam logic [6:0] op_load   = 7'b0000111;
    localparam logic [6:0] op_store  = 7'b0100111;
    localparam logic [6:0] op_arith  = 7'b1010011;
    localparam logic [6:0] op_fmadd  = 7'b1000011;
    localparam logic [6:0] op_fmsub  = 7'b1000111;
    localparam logic [6:0] op_fnmsub = 7'b1001011;
    localparam logic [6:0] op_fnmadd = 7'b1001111;

    // fpu operation select
    localparam logic [4:0] sel_fadd      = 5'd0;
    localparam logic [4:0] sel_fsub      = 5'd1;
    localparam logic [4:0] sel_fmul      = 5'd2;
    localparam logic [4:0] sel_fdiv      = 5'd3;
    localparam logic [4:0] sel_fsqrt     = 5'd4;
    localparam logic [4:0] sel_fsgnj     = 5'd5;
    localparam logic [4:0] sel_fsgnjn    = 5'd6;
    localparam logic [4:0] sel_fsgnjx    = 5'd7;
    localparam logic [4:0] sel_fmax      = 5'd8;
    localparam logic [4:0] sel_fmin      = 5'd9;
    localparam logic [4:0] sel_feq       = 5'd10;
    localparam logic [4:0] sel_flt       = 5'd11;
    localparam logic [4:0] sel_fle       = 5'd12;
    localparam logic [4:0] sel_fmv_x_w   = 5'd13;
    localparam logic [4:0] sel_fclass    = 5'd14;
    localparam logic [4:0] sel_fmv_w_x   = 5'd15;
    localparam logic [4:0] sel_fmadd     = 5'd16;
    localparam logic [4:0] sel_fmsub     = 5'd17;
    localparam logic [4:0] sel_fnmsub    = 5'd18;
    localparam logic [4:0] sel_fnmadd    = 5'd19;
    localparam logic [4:0] sel_fcvt_w_s  = 5'd20;
    localparam logic [4:0] sel_fcvt_wu_s = 5'd21;
    localparam logic [4:0] sel_fcvt_s_w  = 5'd22;
    localparam logic [4:0] sel_fcvt_s_wu = 5'd23;
    localparam logic [4:0] sel_none      = 5'b11111;

    ////////////////////////////////////////
    // result word layout, low bit of each field
    localparam int res_w        = 32;
    localparam int res_sel      = 0;     // 5 bits
    localparam int res_rm       = 5;     // 3 bits
    localparam int res_memread  = 8;
    localparam int res_memwrite = 9;
    localparam int res_regwrite = 10;
    localparam int res_fpusrc   = 11;
    localparam int res_illegal  = 12;
    localparam int res_rd       = 13;    // 5 bits
    localparam int res_valid    = 31;

    // bus word addresses
    localparam logic [1:0] addr_ins  = 2'd0;
    localparam logic [1:0] addr_res  = 2'd1;
    localparam logic [1:0] addr_stat = 2'd2;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [4:0] rs3;
            logic [1:0] fmt;     // 00 is single precision
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] rm;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r4;
    } fp_ins_u;

endpackage

`default_nettype wire

/* hdl/fpd_lane_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fpd_lane_if;
    import fpd_pkg::*;

    logic             ins_valid;
    fp_ins_u          ins;
    logic             ins_ready;
    logic             res_valid;
    logic [res_w-1:0] res;
    logic             res_take;

    modport dispatch (output ins_valid, output ins, input ins_ready);

    modport lane (
        input  ins_valid, ins, res_take,
        output ins_ready, res_valid, res
    );

    // collector also watches acceptances for its in-flight count
    modport collect (
        input  ins_valid, ins_ready, res_valid, res,
        output res_take
    );

endinterface

`default_nettype wire

/* hdl/fpd_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fpd_bus_port (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [1:0]                wb_adr,
    input  logic [31:0]               wb_dat_w,
    output logic [31:0]               wb_dat_r,
    output logic                      wb_ack,
    output logic                      push,
    output fpd_pkg::fp_ins_u          push_data,
    input  logic                      push_done,
    output logic                      pop,
    input  logic [fpd_pkg::res_w-1:0] head_res,
    input  logic                      head_valid,
    input  logic [3:0]                in_flight
);
    import fpd_pkg::*;

    logic             cyc_start;
    logic             ack_go;
    logic [res_w-1:0] rd_word;

    // live strobe not yet acked
    assign cyc_start = wb_cyc & wb_stb & ~wb_ack;

    assign push      = cyc_start & wb_we & (wb_adr == addr_ins);
    assign push_data = wb_dat_w;
    assign pop       = cyc_start & ~wb_we & (wb_adr == addr_res) & head_valid;

    // instruction writes wait for the lane, everything else acks next cycle
    assign ack_go = cyc_start & (push ? push_done : 1'b1);

    always_comb begin
        rd_word = '0;
        case (wb_adr)
            addr_res: begin
                if (head_valid) begin
                    rd_word            = head_res;
                    rd_word[res_valid] = 1'b1;
                end
            end
            addr_stat: rd_word = {{(res_w-4){1'b0}}, in_flight};
            default:   rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= ack_go;
        end
    end

    always_ff @(posedge clk) begin
        if (cyc_start && !wb_we) begin
            wb_dat_r <= rd_word;    // sampled with the pop
        end
    end

    // classic cycles, one ack pulse per strobe
    assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* hdl/fpd_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module fpd_dispatch #(
    parameter int LANES = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             push,
    input  fpd_pkg::fp_ins_u push_data,
    output logic             push_done,
    fpd_lane_if.dispatch     lanes [LANES]
);
    localparam int pw = (LANES > 1) ? $clog2(LANES) : 1;

    logic [pw-1:0]    ptr;
    logic [LANES-1:0] ready;

    ////////////////////////////////////////
    // per-lane fan out
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        assign ready[g]        = lanes[g].ins_ready;
        assign lanes[g].ins    = push_data;
        assign lanes[g].ins_valid = push_done && (ptr == pw'(g));

        // only a lane with a free slot ever sees a word
        assert property (@(posedge clk) disable iff (!arst_n)
            lanes[g].ins_valid |-> lanes[g].ins_ready);
    end

    // stalls here while the pointed lane is still full
    assign push_done = push & ready[ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (push_done) begin
            if (ptr == pw'(LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fp_ctrl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_ctrl_decode (
    input  logic     clk,
    input  logic     arst_n,
    fpd_lane_if.lane port
);
    import fpd_pkg::*;

    fp_ins_u    ins_q;
    logic       full;
    logic       accept;
    logic [4:0] sel;
    logic [2:0] rm;
    logic [4:0] rd;
    logic       memread;
    logic       memwrite;
    logic       regwrite;
    logic       fpusrc;
    logic       illegal;

    assign accept         = port.ins_valid & port.ins_ready;
    assign port.ins_ready = ~full;
    assign port.res_valid = full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (port.res_take) begin
            full <= 1'b0;   // slot free again
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ins_q <= port.ins;
        end
    end

    ////////////////////////////////////////
    // instruction classify
    always_comb begin
        sel      = sel_none;
        rm       = 3'b000;
        rd       = ins_q.r.rd;
        memread  = 1'b0;
        memwrite = 1'b0;
        regwrite = 1'b0;
        fpusrc   = 1'b0;
        illegal  = 1'b0;
        case (ins_q.r.opcode)
            op_load: begin
                memread  = 1'b1;
                regwrite = 1'b1;
                fpusrc   = 1'b1;
                illegal  = ins_q.r.funct3 != 3'b010;    // flw only
            end
            op_store: begin
                memwrite = 1'b1;
                fpusrc   = 1'b1;
                illegal  = ins_q.r.funct3 != 3'b010;
            end
            op_arith: begin
                regwrite = 1'b1;
                fpusrc   = 1'b1;
                case (ins_q.r.funct7)
                    7'h00: begin sel = sel_fadd;  rm = ins_q.r.funct3; end
                    7'h04: begin sel = sel_fsub;  rm = ins_q.r.funct3; end
                    7'h08: begin sel = sel_fmul;  rm = ins_q.r.funct3; end
                    7'h0c: begin sel = sel_fdiv;  rm = ins_q.r.funct3; end
                    7'h2c: begin sel = sel_fsqrt; rm = ins_q.r.funct3; end
                    7'h10: begin
                        case (ins_q.r.funct3)
                            3'b000:  sel = sel_fsgnj;
                            3'b001:  sel = sel_fsgnjn;
                            3'b010:  sel = sel_fsgnjx;
                            default: illegal = 1'b1;
                        endcase
                    end
                    7'h14: begin
                        case (ins_q.r.funct3)
                            3'b000:  sel = sel_fmax;
                            3'b001:  sel = sel_fmin;
                            default: illegal = 1'b1;
                        endcase
                    end
                    7'h50: begin
                        case (ins_q.r.funct3)
                            3'b010:  sel = sel_feq;
                            3'b001:  sel = sel_flt;
                            3'b000:  sel = sel_fle;
                            default: illegal = 1'b1;
                        endcase
                    end
                    7'h60, 7'h68: begin     // float to int, int to float
                        rm = ins_q.r.funct3;
                        case ({ins_q.r.funct7[3], ins_q.r.rs2})
                            6'h00:   sel = sel_fcvt_w_s;
                            6'h01:   sel = sel_fcvt_wu_s;
                            6'h20:   sel = sel_fcvt_s_w;
                            6'h21:   sel = sel_fcvt_s_wu;
                            default: illegal = 1'b1;
                        endcase
                    end
                    7'h70: begin
                        rm = ins_q.r.funct3;
                        case ({ins_q.r.rs2, ins_q.r.funct3})
                            {5'h00, 3'b000}: sel = sel_fmv_x_w;
                            {5'h00, 3'b001}: sel = sel_fclass;
                            default:         illegal = 1'b1;
                        endcase
                    end
                    7'h78: begin
                        if (ins_q.r.rs2 == 5'h00 && ins_q.r.funct3 == 3'b000) begin
                            sel = sel_fmv_w_x;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    default: illegal = 1'b1;
                endcase
            end
            op_fmadd, op_fmsub, op_fnmsub, op_fnmadd: begin
                regwrite = 1'b1;
                fpusrc   = 1'b1;
                rm       = ins_q.r4.rm;
                illegal  = ins_q.r4.fmt != 2'b00;
                case (ins_q.r4.opcode[3:2])   // sub-op sits in opcode bits 3:2
                    2'b00:   sel = sel_fmadd;
                    2'b01:   sel = sel_fmsub;
                    2'b10:   sel = sel_fnmsub;
                    default: sel = sel_fnmadd;
                endcase
            end
            default: illegal = 1'b1;
        endcase

        // illegal word carries nothing but its flag
        if (illegal) begin
            sel      = sel_none;
            rm       = 3'b000;
            rd       = 5'd0;
            memread  = 1'b0;
            memwrite = 1'b0;
            regwrite = 1'b0;
            fpusrc   = 1'b0;
        end
    end

    always_comb begin
        port.res                       = '0;
        port.res[res_sel +: 5]         = sel;
        port.res[res_rm +: 3]          = rm;
        port.res[res_memread]          = memread;
        port.res[res_memwrite]         = memwrite;
        port.res[res_regwrite]         = regwrite;
        port.res[res_fpusrc]           = fpusrc;
        port.res[res_illegal]          = illegal;
        port.res[res_rd +: 5]          = rd;
    end

    // a result only ever follows a word taken in the cycle before
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(port.res_valid) |-> $past(port.ins_valid && port.ins_ready));

endmodule

`default_nettype wire

/* hdl/fpd_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module fpd_collect #(
    parameter int LANES = 4
) (
    input  logic                      clk,
    input  logic                      arst_n,
    fpd_lane_if.collect               lanes [LANES],
    input  logic                      pop,
    output logic [fpd_pkg::res_w-1:0] head_res,
    output logic                      head_valid,
    output logic [3:0]                in_flight
);
    import fpd_pkg::*;

    localparam int pw = (LANES > 1) ? $clog2(LANES) : 1;

    logic [pw-1:0]    ptr;
    logic [LANES-1:0] valid;
    logic [LANES-1:0] taken_in;     // acceptance seen per lane
    logic [res_w-1:0] res_arr [LANES];
    logic             drain;

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        assign valid[g]          = lanes[g].res_valid;
        assign res_arr[g]        = lanes[g].res;
        assign taken_in[g]       = lanes[g].ins_valid & lanes[g].ins_ready;
        assign lanes[g].res_take = pop && (ptr == pw'(g)) && valid[g];
    end

    assign head_valid = valid[ptr];
    assign head_res   = res_arr[ptr];
    assign drain      = pop & head_valid;

    ////////////////////////////////////////
    // drain pointer and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr       <= '0;
            in_flight <= 4'd0;
        end else begin
            if (drain) begin
                ptr <= (ptr == pw'(LANES - 1)) ? '0 : ptr + 1'b1;
            end
            case ({|taken_in, drain})
                2'b10:   in_flight <= in_flight + 4'd1;
                2'b01:   in_flight <= in_flight - 4'd1;
                default: in_flight <= in_flight;    // none, or one in and one out
            endcase
        end
    end

    // never more words in flight than lanes to hold them
    assert property (@(posedge clk) disable iff (!arst_n) in_flight <= 4'(LANES));

endmodule

`default_nettype wire

/* hdl/fpd_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module fpd_cluster #(
    parameter int LANES = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);
    import fpd_pkg::*;

    logic             push;
    fp_ins_u          push_data;
    logic             push_done;
    logic             pop;
    logic [res_w-1:0] head_res;
    logic             head_valid;
    logic [3:0]       in_flight;

    fpd_lane_if lane_bus [LANES] ();

    fpd_bus_port u_bus (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .push      (push),
        .push_data (push_data),
        .push_done (push_done),
        .pop       (pop),
        .head_res  (head_res),
        .head_valid(head_valid),
        .in_flight (in_flight)
    );

    fpd_dispatch #(.LANES(LANES)) u_dispatch (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .push_data(push_data),
        .push_done(push_done),
        .lanes    (lane_bus)
    );

    for (genvar g = 0; g < LANES; g++) begin : g_dec
        fp_ctrl_decode u_lane (
            .clk   (clk),
            .arst_n(arst_n),
            .port  (lane_bus[g])
        );
    end

    fpd_collect #(.LANES(LANES)) u_collect (
        .clk       (clk),
        .arst_n    (arst_n),
        .lanes     (lane_bus),
        .pop       (pop),
        .head_res  (head_res),
        .head_valid(head_valid),
        .in_flight (in_flight)
    );

endmodule

`default_nettype wire

/* tb/fpd_cluster_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fpd_cluster_tb;
    import fpd_pkg::*;

    localparam int n_lanes    = 4;
    localparam int max_cycles = 4000;   // all tests need about 1500

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int cycles = 0;
    int seed_val;

    fpd_cluster #(.LANES(n_lanes)) uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // instruction builders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r4_word(input logic [4:0] rs3, input logic [1:0] fmt,
                                            input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [2:0] rm, input logic [4:0] rd,
                                            input logic [6:0] opc);
        return {rs3, fmt, rs2, rs1, rm, rd, opc};
    endfunction

    // expected result word as the bus returns it
    function automatic logic [31:0] ref_decode(input logic [31:0] w);
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [4:0] rs2;
        logic [4:0] sel;
        logic [2:0] rm;
        logic       mr;
        logic       mw;
        logic       rw;
        logic       bad;
        opc = w[6:0];
        f3  = w[14:12];
        rs2 = w[24:20];
        f7  = w[31:25];
        sel = sel_none;
        rm  = 3'b000;
        mr  = 1'b0;
        mw  = 1'b0;
        rw  = 1'b0;
        case (opc)
            op_load: begin
                mr  = 1'b1;
                rw  = 1'b1;
                bad = f3 != 3'b010;
            end
            op_store: begin
                mw  = 1'b1;
                bad = f3 != 3'b010;
            end
            op_fmadd, op_fmsub, op_fnmsub, op_fnmadd: begin
                rw  = 1'b1;
                rm  = f3;                   // r4 rm shares the funct3 slot
                bad = w[26:25] != 2'b00;
                case (opc)
                    op_fmadd:  sel = sel_fmadd;
                    op_fmsub:  sel = sel_fmsub;
                    op_fnmsub: sel = sel_fnmsub;
                    default:   sel = sel_fnmadd;
                endcase
            end
            op_arith: begin
                rw = 1'b1;
                case (f7)
                    7'h00, 7'h04, 7'h08, 7'h0c, 7'h2c, 7'h60, 7'h68, 7'h70: rm = f3;
                    default: rm = 3'b000;
                endcase
                case (f7)
                    7'h00: sel = sel_fadd;
                    7'h04: sel = sel_fsub;
                    7'h08: sel = sel_fmul;
                    7'h0c: sel = sel_fdiv;
                    7'h2c: sel = sel_fsqrt;
                    7'h10: sel = f3 == 0 ? sel_fsgnj : f3 == 1 ? sel_fsgnjn :
                                 f3 == 2 ? sel_fsgnjx : sel_none;
                    7'h14: sel = f3 == 0 ? sel_fmax : f3 == 1 ? sel_fmin : sel_none;
                    7'h50: sel = f3 == 2 ? sel_feq : f3 == 1 ? sel_flt :
                                 f3 == 0 ? sel_fle : sel_none;
                    7'h60: sel = rs2 == 0 ? sel_fcvt_w_s : rs2 == 1 ? sel_fcvt_wu_s : sel_none;
                    7'h68: sel = rs2 == 0 ? sel_fcvt_s_w : rs2 == 1 ? sel_fcvt_s_wu : sel_none;
                    7'h70: sel = rs2 != 0 ? sel_none : f3 == 0 ? sel_fmv_x_w :
                                 f3 == 1 ? sel_fclass : sel_none;
                    7'h78: sel = (rs2 == 0 && f3 == 0) ? sel_fmv_w_x : sel_none;
                    default: sel = sel_none;
                endcase
                bad = sel == sel_none;      // every legal arith op has a select
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            return 32'h8000_1000 | 32'(sel_none);
        end
        // valid, pad, rd, illegal, fpusrc, regwrite, memwrite, memread, rm, sel
        return {1'b1, 13'd0, w[11:7], 1'b0, 1'b1, rw, mw, mr, rm, sel};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [6:0]  f7_tab [13] = '{7'h00, 7'h04, 7'h08, 7'h0c, 7'h2c, 7'h10, 7'h14,
                                     7'h50, 7'h60, 7'h68, 7'h70, 7'h78, 7'h7f};
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(9, 0))
            0: begin
                w[6:0]   = op_load;
                w[14:12] = 3'b010;
            end
            1: begin
                w[6:0]   = op_store;
                w[14:12] = 3'b010;
            end
            2, 3, 4, 5: begin
                w[6:0]   = op_arith;
                w[31:25] = f7_tab[$urandom_range(12, 0)];
                w[24:20] = 5'($urandom_range(2, 0));   // hits cvt and fmv rs2 codes
            end
            6: w[6:0] = op_fmadd;
            7: w[6:0] = op_fnmadd;
            8: w[6:0] = $urandom_range(1, 0) ? op_fmsub : op_fnmsub;
            default: ;                                  // raw random word
        endcase
        if (w[6:4] == 3'b100 && $urandom_range(3, 0) != 0) begin
            w[26:25] = 2'b00;
        end
        return w;
    endfunction

    ////////////////////////////////////////
    // bus access and checking
    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                             input int max_wait, output logic acked, output logic [31:0] rdat);
        int n;
        n     = 0;
        acked = 1'b0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        while (!acked && n < max_wait) begin
            @(negedge clk);
            n++;
            acked = wb_ack;
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;     // also ends an abandoned write
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input string name, input logic [1:0] adr, input logic [31:0] data);
        logic        acked;
        logic [31:0] rdat;
        bus_cycle(1'b1, adr, data, 50, acked, rdat);
        if (!acked) begin
            errors++;
            $display("%s: write to address %0d was never acknowledged", name, adr);
        end
    endtask

    task automatic wb_read(input string name, input logic [1:0] adr, output logic [31:0] data);
        logic acked;
        bus_cycle(1'b0, adr, 32'd0, 50, acked, data);
        if (!acked) begin
            errors++;
            $display("%s: read of address %0d was never acknowledged", name, adr);
        end
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic push_and_check(input string name, input logic [31:0] w);
        logic [31:0] d;
        wb_write(name, addr_ins, w);
        wb_read(name, addr_res, d);
        check_eq(name, ref_decode(w), d);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("test %s finished, %0d errors", name, errors - err_start);
    endtask

    ////////////////////////////////////////
    // directed tests
    task automatic test_legal();
        logic [6:0] ar_f7 [5] = '{7'h00, 7'h04, 7'h08, 7'h0c, 7'h2c};
        logic [6:0] r4_op [4] = '{op_fmadd, op_fmsub, op_fnmsub, op_fnmadd};
        int         e;
        e = errors;
        push_and_check("flw", r_word(7'h15, 5'd3, 5'd2, 3'b010, 5'd9, op_load));
        push_and_check("fsw", r_word(7'h01, 5'd4, 5'd2, 3'b010, 5'd17, op_store));
        foreach (ar_f7[i]) begin
            push_and_check("arith", r_word(ar_f7[i], 5'd0, 5'd1, 3'(i), 5'(i + 1), op_arith));
        end
        for (int i = 0; i < 3; i++) begin
            push_and_check("sgnj", r_word(7'h10, 5'd5, 5'd6, 3'(i), 5'd7, op_arith));
            push_and_check("compare", r_word(7'h50, 5'd5, 5'd6, 3'(i), 5'd8, op_arith));
        end
        for (int i = 0; i < 2; i++) begin
            push_and_check("minmax", r_word(7'h14, 5'd1, 5'd2, 3'(i), 5'd10, op_arith));
            push_and_check("fcvt.w", r_word(7'h60, 5'(i), 5'd2, 3'd1, 5'd11, op_arith));
            push_and_check("fcvt.s", r_word(7'h68, 5'(i), 5'd2, 3'd4, 5'd12, op_arith));
            push_and_check("fmv.x.w/fclass", r_word(7'h70, 5'd0, 5'd3, 3'(i), 5'd13, op_arith));
        end
        push_and_check("fmv.w.x", r_word(7'h78, 5'd0, 5'd3, 3'd0, 5'd14, op_arith));
        foreach (r4_op[i]) begin
            push_and_check("r4", r4_word(5'(i), 2'b00, 5'd2, 5'd1, 3'(i), 5'(20 + i), r4_op[i]));
        end
        report_test("legal", e);
    endtask

    task automatic test_illegal();
        int e;
        e = errors;
        push_and_check("bad flw width", r_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd3, op_load));
        push_and_check("bad fsw width", r_word(7'h00, 5'd1, 5'd2, 3'b000, 5'd3, op_store));
        push_and_check("bad sgnj", r_word(7'h10, 5'd1, 5'd2, 3'b011, 5'd3, op_arith));
        push_and_check("bad cvt rs2", r_word(7'h60, 5'd2, 5'd2, 3'b000, 5'd3, op_arith));
        push_and_check("bad fmv rs2", r_word(7'h70, 5'd1, 5'd2, 3'b000, 5'd3, op_arith));
        push_and_check("bad funct7", r_word(7'h7f, 5'd1, 5'd2, 3'b000, 5'd3, op_arith));
        push_and_check("bad opcode", r_word(7'h00, 5'd1, 5'd2, 3'b000, 5'd3, 7'h33));
        push_and_check("bad r4 fmt", r4_word(5'd4, 2'b01, 5'd1, 5'd2, 3'd0, 5'd3, op_fmsub));
        report_test("illegal", e);
    endtask

    task automatic test_empty_read();
        logic [31:0] d;
        int          e;
        e = errors;
        wb_read("empty", addr_res, d);
        check_eq("empty result", 32'd0, d);
        wb_read("empty", addr_stat, d);
        check_eq("empty in flight", 32'd0, d);
        report_test("empty_read", e);
    endtask

    task automatic test_backpressure();
        logic [31:0] words [n_lanes + 2];
        logic [31:0] d;
        logic        acked;
        int          e;
        e = errors;
        foreach (words[i]) begin
            words[i] = r_word(7'h08, 5'(i), 5'(i + 1), 3'd0, 5'(i + 2), op_arith);
        end
        for (int i = 0; i < n_lanes; i++) begin
            wb_write("backpressure", addr_ins, words[i]);
        end
        wb_read("backpressure", addr_stat, d);
        check_eq("backpressure in flight", n_lanes, d);
        for (int i = n_lanes; i < n_lanes + 2; i++) begin
            bus_cycle(1'b1, addr_ins, words[i], 10, acked, d);  // every lane full
            check_eq("backpressure stall", 32'd0, {31'd0, acked});
            wb_read("backpressure", addr_res, d);
            check_eq("backpressure order", ref_decode(words[i - n_lanes]), d);
            wb_write("backpressure", addr_ins, words[i]);
        end
        for (int i = 2; i < n_lanes + 2; i++) begin
            wb_read("backpressure", addr_res, d);
            check_eq("backpressure order", ref_decode(words[i]), d);
        end
        report_test("backpressure", e);
    endtask

    task automatic test_random();
        logic [31:0] exp_q [$];
        logic [31:0] w;
        logic [31:0] d;
        int          e;
        e = errors;
        for (int i = 0; i < 200; i++) begin
            w = rand_word();
            wb_write("random", addr_ins, w);
            exp_q.push_back(ref_decode(w));
            if (exp_q.size() == n_lanes || $urandom_range(1, 0) == 1) begin
                wb_read("random", addr_res, d);
                check_eq("random result", exp_q.pop_front(), d);
            end
            if (i % 8 == 0) begin
                wb_read("random", addr_stat, d);
                check_eq("random in flight", exp_q.size(), d);
            end
        end
        while (exp_q.size() > 0) begin
            wb_read("random", addr_res, d);
            check_eq("random result", exp_q.pop_front(), d);
        end
        wb_read("random", addr_stat, d);
        check_eq("random in flight", 32'd0, d);
        report_test("random", e);
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_w = 32'd0;
        seed_val = $urandom(32'h27ef0750);
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_legal();
        test_illegal();
        test_empty_read();
        test_backpressure();
        test_random();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fpd_cluster.f */
hdl/fpd_pkg.sv
hdl/fpd_lane_if.sv
hdl/fpd_bus_port.sv
hdl/fpd_dispatch.sv
hdl/fp_ctrl_decode.sv
hdl/fpd_collect.sv
hdl/fpd_cluster.sv
tb/fpd_cluster_tb.sv
